// File: filelist.f
noc_params.sv
flit_pkg.sv
round_robin_arbiter.sv
separable_input_first_allocator.sv
switch_allocator.sv
input_port.sv
crossbar.sv
router.sv
tb_router.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TOP        ?= tb_router
RTL_TOP    ?= router
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= $(filter-out tb_%.sv,$(shell grep -v '^+' $(FILELIST)))

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_router.sv
`timescale 1ns/1ps

module tb_router
    import noc_params::*;
    import flit_pkg::*;
();

    localparam int FIFO_DEPTH = 4;
    localparam int ROUTER_X   = 2;
    localparam int ROUTER_Y   = 2;

    logic                             clk;
    logic                             rst_n_i;
    logic  [PORT_NUM-1:0]             flit_valid_i;
    flit_t [PORT_NUM-1:0]             flit_i;
    logic  [PORT_NUM-1:0][VC_NUM-1:0] on_off_o;
    flit_t [PORT_NUM-1:0]             flit_o;
    logic  [PORT_NUM-1:0]             valid_o;
    logic  [PORT_NUM-1:0][VC_NUM-1:0] on_off_i;

    // Scoreboard, one queue per output and VC.
    flit_t                            exp_q [PORT_NUM][VC_NUM][$];
    integer                           seed        = 32'h431b;
    int                               sent_count  = 0;
    int                               cycle_cnt   = 0;
    logic                             bp_done     = 1'b0;
    logic  [PORT_NUM-1:0]             chk_valid   = '0;
    logic  [PORT_NUM-1:0]             chk_ok      = '1;
    logic  [PORT_NUM-1:0]             blocked_hit = '0;
    flit_t [PORT_NUM-1:0]             exp_flit    = '0;
    flit_t [PORT_NUM-1:0]             act_flit    = '0;
    logic  [PORT_NUM-1:0][VC_NUM-1:0] on_off_prev = '1;    // Downstream state at grant time.

    router #(
        .VC_NUM     (VC_NUM),
        .FIFO_DEPTH (FIFO_DEPTH),
        .ROUTER_X   (ROUTER_X),
        .ROUTER_Y   (ROUTER_Y)
    ) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flit_valid_i (flit_valid_i),
        .flit_i       (flit_i),
        .on_off_o     (on_off_o),
        .flit_o       (flit_o),
        .valid_o      (valid_o),
        .on_off_i     (on_off_i)
    );

    // X first, then y.
    function automatic port_e xy_output(input int dx, input int dy);
        if (dx > ROUTER_X)
            return EAST;
        if (dx < ROUTER_X)
            return WEST;
        if (dy > ROUTER_Y)
            return NORTH;
        if (dy < ROUTER_Y)
            return SOUTH;
        return LOCAL;
    endfunction

    // Bits 23:21 of every payload carry the source port.
    function automatic flit_t make_flit(input flit_type_e kind, input int vc, input int src,
                                        input int dx, input int dy, input int tag);
        flit_t f;
        f.flit_type = kind;
        f.vc_id     = VC_SIZE'(vc);
        if (kind == HEAD || kind == HEADTAIL)
        begin
            f.payload.head.dest_x = COORD_SIZE'(dx);
            f.payload.head.dest_y = COORD_SIZE'(dy);
            f.payload.head.data   = {3'(src), 21'(tag)};
        end
        else
            f.payload.data = {8'(tag >> 21), 3'(src), 21'(tag)};
        return f;
    endfunction

    function automatic int pending_flits();
        int total;
        total = 0;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            for (int v = 0; v < VC_NUM; v++)
                total += exp_q[o][v].size();
        end
        return total;
    endfunction

    task automatic drive_flit(input int port, input flit_t f, input port_e out);
        @(posedge clk);
        while (!on_off_o[port][f.vc_id])
        begin
            flit_valid_i[port] <= 1'b0;
            @(posedge clk);
        end
        flit_valid_i[port] <= 1'b1;
        flit_i[port]       <= f;
        exp_q[out][f.vc_id].push_back(f);
        sent_count++;
    endtask

    task automatic idle_link(input int port);
        @(posedge clk);
        flit_valid_i[port] <= 1'b0;
    endtask

    task automatic send_packet(input int port, input int vc, input int dx, input int dy,
                               input int len);
        port_e      out;
        flit_type_e kind;
        out = xy_output(dx, dy);
        for (int i = 0; i < len; i++)
        begin
            if (len == 1)
                kind = HEADTAIL;
            else if (i == 0)
                kind = HEAD;
            else if (i == len - 1)
                kind = TAIL;
            else
                kind = BODY;
            drive_flit(port, make_flit(kind, vc, port, dx, dy, $random(seed)), out);
        end
    endtask

    // Packets to one destination on alternating VCs.
    task automatic stream_packets(input int port, input int count, input int dx, input int dy,
                                  input int len);
        for (int i = 0; i < count; i++)
            send_packet(port, i % VC_NUM, dx, dy, len);
        idle_link(port);
    endtask

    task automatic random_traffic(input int port, input int packets);
        int dx;
        int dy;
        int len;
        for (int i = 0; i < packets; i++)
        begin
            dx  = $unsigned($random(seed)) % 5;
            dy  = $unsigned($random(seed)) % 5;
            len = 1 + $unsigned($random(seed)) % 4;
            send_packet(port, i % VC_NUM, dx, dy, len);
        end
        idle_link(port);
    endtask

    task automatic toggle_backpressure();
        logic [PORT_NUM-1:0][VC_NUM-1:0] pattern;
        while (!bp_done)
        begin
            @(posedge clk);
            for (int o = 0; o < PORT_NUM; o++)
            begin
                for (int v = 0; v < VC_NUM; v++)
                    pattern[o][v] = ($unsigned($random(seed)) % 4) != 0;    // Mostly on.
            end
            on_off_i <= pattern;
        end
    endtask

    task automatic drain_all();
        while (pending_flits() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    // Matches each delivery against the oldest pending flit from the same source.
    task automatic check_outputs();
        int    vc;
        int    idx;
        flit_t got;
        forever
        begin
            @(negedge clk);
            for (int o = 0; o < PORT_NUM; o++)
            begin
                chk_valid[o]   = 1'b0;
                chk_ok[o]      = 1'b1;
                blocked_hit[o] = 1'b0;
                if (rst_n_i && valid_o[o])
                begin
                    got = flit_o[o];
                    vc  = int'(got.vc_id);
                    idx = -1;
                    for (int i = exp_q[o][vc].size() - 1; i >= 0; i--)
                    begin
                        if (exp_q[o][vc][i].payload.data[23:21] == got.payload.data[23:21])
                            idx = i;
                    end
                    chk_valid[o]   = 1'b1;
                    act_flit[o]    = got;
                    blocked_hit[o] = !on_off_prev[o][vc];
                    if (idx < 0)
                    begin
                        exp_flit[o] = '0;    // Nothing pending from that source.
                        chk_ok[o]   = 1'b0;
                    end
                    else
                    begin
                        exp_flit[o] = exp_q[o][vc][idx];
                        chk_ok[o]   = (exp_flit[o] == got);
                        exp_q[o][vc].delete(idx);
                    end
                end
            end
            on_off_prev = on_off_i;
        end
    endtask

    for (genvar o = 0; o < PORT_NUM; o++)
    begin : g_output_check
        assert property (@(posedge clk) disable iff (!rst_n_i) !chk_valid[o] || chk_ok[o])
        else
        begin
            $display("[FAIL] flit_o[%0d] exp %h act %h", o, exp_flit[o], act_flit[o]);
            $display("tests failed");
            $fatal(1);
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) !blocked_hit[o])
        else
        begin
            $display("[FAIL] valid_o[%0d] vc %0d with on_off_i low, exp 0 act 1",
                     o, act_flit[o].vc_id);
            $display("tests failed");
            $fatal(1);
        end
    end

    assert property (@(posedge clk) $rose(rst_n_i) |-> (valid_o == '0))
    else
    begin
        $display("[FAIL] valid_o after reset exp %h act %h", {PORT_NUM{1'b0}}, valid_o);
        $display("tests failed");
        $fatal(1);
    end

    assert property (@(posedge clk) $rose(rst_n_i) |-> (&on_off_o))
    else
    begin
        $display("[FAIL] on_off_o after reset exp %h act %h",
                 {(PORT_NUM * VC_NUM){1'b1}}, on_off_o);
        $display("tests failed");
        $fatal(1);
    end

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > 40 * sent_count + 200)
        begin
            $display("Timeout after %0d cycles with %0d flits undelivered",
                     cycle_cnt, pending_flits());
            $display("tests failed");
            $fatal(1);
        end
    end

    initial
    begin
        int dest_x [5];
        int dest_y [5];
        rst_n_i      = 1'b0;
        flit_valid_i = '0;
        flit_i       = '0;
        on_off_i     = '1;
        dest_x       = '{3, 1, 2, 2, 3};
        dest_y       = '{2, 2, 3, 1, 0};
        fork
            check_outputs();
        join_none
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk);

        // Single flit to this router's own tile.
        send_packet(LOCAL, 0, 2, 2, 1);
        idle_link(LOCAL);
        drain_all();

        // East, west, north, south, east.
        for (int i = 0; i < 5; i++)
        begin
            send_packet(LOCAL, i % VC_NUM, dest_x[i], dest_y[i], 1);
            idle_link(LOCAL);
            drain_all();
        end

        // Mixed wormhole traffic under random downstream back-pressure.
        fork
            begin
                fork
                    random_traffic(LOCAL, 6);
                    random_traffic(NORTH, 6);
                    random_traffic(SOUTH, 6);
                    random_traffic(EAST, 6);
                    random_traffic(WEST, 6);
                join
                bp_done = 1'b1;
            end
            toggle_backpressure();
        join
        on_off_i <= '1;
        drain_all();

        // Four inputs compete for the west output.
        fork
            stream_packets(LOCAL, 3, 0, 2, 3);
            stream_packets(NORTH, 3, 1, 4, 3);
            stream_packets(SOUTH, 3, 0, 0, 3);
            stream_packets(EAST, 3, 1, 2, 3);
        join
        drain_all();

        // East VC 0 held off downstream, VC 1 keeps moving.
        on_off_i[EAST][0] <= 1'b0;
        fork
            stream_packets(NORTH, 2, 4, 1, 3);
            stream_packets(LOCAL, 2, 3, 3, 2);
            begin
                repeat (30) @(posedge clk);
                on_off_i[EAST][0] <= 1'b1;
            end
        join
        drain_all();

        // Fill the south input VC 1 until it turns its upstream off.
        on_off_i[NORTH][1] <= 1'b0;
        fork
            begin
                send_packet(SOUTH, 1, 2, 4, 6);
                idle_link(SOUTH);
            end
            begin
                @(posedge clk);
                while (on_off_o[SOUTH][1])
                    @(posedge clk);
                repeat (5) @(posedge clk);
                assert (!on_off_o[SOUTH][1])
                else
                begin
                    $display("[FAIL] on_off_o[%0d][1] exp 0 act %h", SOUTH, on_off_o[SOUTH][1]);
                    $display("tests failed");
                    $fatal(1);
                end
                on_off_i[NORTH][1] <= 1'b1;
            end
        join
        drain_all();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: router.sv
`timescale 1ns/1ps

module router
    import noc_params::*;
    import flit_pkg::*;
#(
    parameter int VC_NUM     = noc_params::VC_NUM,
    parameter int FIFO_DEPTH = 4,
    parameter int ROUTER_X   = 0,
    parameter int ROUTER_Y   = 0
)(
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic  [PORT_NUM-1:0]             flit_valid_i,
    input  flit_t [PORT_NUM-1:0]             flit_i,
    output logic  [PORT_NUM-1:0][VC_NUM-1:0] on_off_o,
    output flit_t [PORT_NUM-1:0]             flit_o,
    output logic  [PORT_NUM-1:0]             valid_o,
    input  logic  [PORT_NUM-1:0][VC_NUM-1:0] on_off_i
);

    logic  [PORT_NUM-1:0][VC_NUM-1:0]                switch_request;
    logic  [PORT_NUM-1:0][VC_NUM-1:0][PORT_SIZE-1:0] out_port;
    logic  [PORT_NUM-1:0][VC_NUM-1:0][VC_SIZE-1:0]   downstream_vc;
    logic  [PORT_NUM-1:0]                            valid_sel;
    logic  [PORT_NUM-1:0][VC_SIZE-1:0]               vc_sel;
    flit_t [PORT_NUM-1:0]                            head_flit;    // Granted flit of each input.
    logic  [PORT_NUM-1:0][PORT_SIZE-1:0]             input_vc_sel;
    logic  [PORT_NUM-1:0]                            grant_valid;

    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_input_port
        input_port #(
            .VC_NUM     (VC_NUM),
            .FIFO_DEPTH (FIFO_DEPTH),
            .ROUTER_X   (ROUTER_X),
            .ROUTER_Y   (ROUTER_Y)
        ) u_input_port (
            .clk              (clk),
            .rst_n_i          (rst_n_i),
            .flit_valid_i     (flit_valid_i[p]),
            .flit_i           (flit_i[p]),
            .on_off_o         (on_off_o[p]),
            .switch_request_o (switch_request[p]),
            .out_port_o       (out_port[p]),
            .downstream_vc_o  (downstream_vc[p]),
            .valid_sel_i      (valid_sel[p]),
            .vc_sel_i         (vc_sel[p]),
            .flit_o           (head_flit[p])
        );
    end

    switch_allocator #(
        .VC_NUM (VC_NUM)
    ) u_switch_allocator (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .on_off_i         (on_off_i),
        .switch_request_i (switch_request),
        .out_port_i       (out_port),
        .downstream_vc_i  (downstream_vc),
        .valid_sel_o      (valid_sel),
        .vc_sel_o         (vc_sel),
        .input_vc_sel_o   (input_vc_sel),
        .grant_valid_o    (grant_valid)
    );

    crossbar #(
        .VC_NUM (VC_NUM)
    ) u_crossbar (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_flit_i      (head_flit),
        .input_vc_sel_i (input_vc_sel),
        .grant_valid_i  (grant_valid),
        .flit_o         (flit_o),
        .valid_o        (valid_o)
    );

endmodule

// File: crossbar.sv
`timescale 1ns/1ps

module crossbar
    import noc_params::*;
    import flit_pkg::*;
#(
    parameter int VC_NUM = noc_params::VC_NUM
)(
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  flit_t [PORT_NUM-1:0]               in_flit_i,
    input  logic  [PORT_NUM-1:0][PORT_SIZE-1:0] input_vc_sel_i,
    input  logic  [PORT_NUM-1:0]               grant_valid_i,
    output flit_t [PORT_NUM-1:0]               flit_o,
    output logic  [PORT_NUM-1:0]               valid_o
);

    flit_t [PORT_NUM-1:0] sel_flit;

    always_comb
    begin
        for (int out = 0; out < PORT_NUM; out++)
            sel_flit[out] = in_flit_i[input_vc_sel_i[out]];
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            valid_o <= '0;
        else
            valid_o <= grant_valid_i;
    end

    always_ff @(posedge clk)
        flit_o <= sel_flit;

endmodule

// File: input_port.sv
`timescale 1ns/1ps

module input_port
    import noc_params::*;
    import flit_pkg::*;
#(
    parameter int VC_NUM     = noc_params::VC_NUM,
    parameter int FIFO_DEPTH = 4,
    parameter int ROUTER_X   = 0,
    parameter int ROUTER_Y   = 0
)(
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flit_valid_i,
    input  flit_t                            flit_i,
    output logic [VC_NUM-1:0]                on_off_o,
    output logic [VC_NUM-1:0]                switch_request_o,
    output logic [VC_NUM-1:0][PORT_SIZE-1:0] out_port_o,
    output logic [VC_NUM-1:0][VC_SIZE-1:0]   downstream_vc_o,
    input  logic                             valid_sel_i,
    input  logic [VC_SIZE-1:0]               vc_sel_i,
    output flit_t                            flit_o
);

    localparam int PTR_SIZE = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_SIZE = $clog2(FIFO_DEPTH + 1);

    flit_t                           mem [VC_NUM][FIFO_DEPTH];
    logic [VC_NUM-1:0][PTR_SIZE-1:0] rd_ptr;
    logic [VC_NUM-1:0][PTR_SIZE-1:0] wr_ptr;
    logic [VC_NUM-1:0][CNT_SIZE-1:0] count;
    flit_t [VC_NUM-1:0]              head_flit;
    logic [VC_NUM-1:0]               is_head;
    logic [VC_NUM-1:0]               push;
    logic [VC_NUM-1:0]               pop;
    logic [VC_NUM-1:0]               route_held;    // Packet in flight on this VC.
    logic [VC_NUM-1:0][PORT_SIZE-1:0] route_q;

    function automatic logic [PTR_SIZE-1:0] ptr_inc(input logic [PTR_SIZE-1:0] ptr);
        return (ptr == PTR_SIZE'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Dimension order routing, x first.
    function automatic port_e xy_route(input head_payload_t hdr);
        port_e dir;
        if (hdr.dest_x > COORD_SIZE'(ROUTER_X))
            dir = EAST;
        else if (hdr.dest_x < COORD_SIZE'(ROUTER_X))
            dir = WEST;
        else if (hdr.dest_y > COORD_SIZE'(ROUTER_Y))
            dir = NORTH;
        else if (hdr.dest_y < COORD_SIZE'(ROUTER_Y))
            dir = SOUTH;
        else
            dir = LOCAL;
        return dir;
    endfunction

    always_comb
    begin
        for (int vc = 0; vc < VC_NUM; vc++)
        begin
            head_flit[vc] = mem[vc][rd_ptr[vc]];
            is_head[vc]   = (head_flit[vc].flit_type == HEAD)
                            || (head_flit[vc].flit_type == HEADTAIL);
            push[vc]      = flit_valid_i && (flit_i.vc_id == VC_SIZE'(vc));
            pop[vc]       = valid_sel_i && (vc_sel_i == VC_SIZE'(vc));
            // Body and tail flits follow the route of their head.
            out_port_o[vc]       = is_head[vc] ? xy_route(head_flit[vc].payload.head)
                                               : route_q[vc];
            switch_request_o[vc] = (count[vc] != '0) && (is_head[vc] || route_held[vc]);
            on_off_o[vc]         = count[vc] <= CNT_SIZE'(FIFO_DEPTH - 2);    // Two free slots.
            downstream_vc_o[vc]  = VC_SIZE'(vc);
        end
    end

    assign flit_o = head_flit[vc_sel_i];

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            route_held <= '0;
            route_q    <= '0;
        end
        else
        begin
            for (int vc = 0; vc < VC_NUM; vc++)
            begin
                if (push[vc])
                    wr_ptr[vc] <= ptr_inc(wr_ptr[vc]);
                if (pop[vc])
                begin
                    rd_ptr[vc] <= ptr_inc(rd_ptr[vc]);
                    if (head_flit[vc].flit_type == HEAD)
                    begin
                        route_held[vc] <= 1'b1;
                        route_q[vc]    <= out_port_o[vc];
                    end
                    else if (head_flit[vc].flit_type != BODY)
                        route_held[vc] <= 1'b0;    // Tail or headtail ends the packet.
                end
                if (push[vc] && !pop[vc])
                    count[vc] <= count[vc] + 1'b1;
                else if (!push[vc] && pop[vc])
                    count[vc] <= count[vc] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int vc = 0; vc < VC_NUM; vc++)
        begin
            if (push[vc])
                mem[vc][wr_ptr[vc]] <= flit_i;
        end
    end

endmodule

// File: switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator
    import noc_params::*;
#(
    parameter int VC_NUM = noc_params::VC_NUM
)(
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic [PORT_NUM-1:0][VC_NUM-1:0]              on_off_i,
    input  logic [PORT_NUM-1:0][VC_NUM-1:0]              switch_request_i,
    input  logic [PORT_NUM-1:0][VC_NUM-1:0][PORT_SIZE-1:0] out_port_i,
    input  logic [PORT_NUM-1:0][VC_NUM-1:0][VC_SIZE-1:0] downstream_vc_i,
    output logic [PORT_NUM-1:0]                          valid_sel_o,
    output logic [PORT_NUM-1:0][VC_SIZE-1:0]             vc_sel_o,
    output logic [PORT_NUM-1:0][PORT_SIZE-1:0]           input_vc_sel_o,
    output logic [PORT_NUM-1:0]                          grant_valid_o
);

    logic [PORT_NUM-1:0][VC_NUM-1:0]   vc_req;      // Requests that may go downstream.
    logic [PORT_NUM-1:0][VC_NUM-1:0]   vc_grant;
    logic [PORT_NUM-1:0][PORT_NUM-1:0] port_req;    // Input by output.
    logic [PORT_NUM-1:0][PORT_NUM-1:0] port_grant;

    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_vc_arb
        round_robin_arbiter #(
            .AGENTS_NUM (VC_NUM)
        ) u_vc_arb (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .requests_i (vc_req[p]),
            .grants_o   (vc_grant[p])
        );
    end

    separable_input_first_allocator #(
        .AGENTS_NUM    (PORT_NUM),
        .RESOURCES_NUM (PORT_NUM)
    ) u_port_alloc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .requests_i (port_req),
        .grants_o   (port_grant)
    );

    // A VC whose downstream buffer is off does not compete.
    always_comb
    begin
        for (int p = 0; p < PORT_NUM; p++)
        begin
            for (int vc = 0; vc < VC_NUM; vc++)
                vc_req[p][vc] = switch_request_i[p][vc]
                                && on_off_i[out_port_i[p][vc]][downstream_vc_i[p][vc]];
        end
    end

    always_comb
    begin
        port_req = '0;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            for (int vc = 0; vc < VC_NUM; vc++)
            begin
                if (vc_grant[p][vc])
                    port_req[p][out_port_i[p][vc]] = 1'b1;
            end
        end
    end

    always_comb
    begin
        valid_sel_o    = '0;
        vc_sel_o       = '0;
        input_vc_sel_o = '0;
        grant_valid_o  = '0;
        for (int in = 0; in < PORT_NUM; in++)
        begin
            for (int vc = 0; vc < VC_NUM; vc++)
            begin
                if (vc_grant[in][vc])
                    vc_sel_o[in] = VC_SIZE'(vc);    // Only looked at with valid_sel_o.
            end
            for (int out = 0; out < PORT_NUM; out++)
            begin
                if (port_grant[in][out])
                begin
                    valid_sel_o[in]     = 1'b1;
                    grant_valid_o[out]  = 1'b1;
                    input_vc_sel_o[out] = PORT_SIZE'(in);
                end
            end
        end
    end

endmodule

// File: separable_input_first_allocator.sv
`timescale 1ns/1ps

module separable_input_first_allocator #(
    parameter int AGENTS_NUM    = 5,
    parameter int RESOURCES_NUM = 5
)(
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic [AGENTS_NUM-1:0][RESOURCES_NUM-1:0] requests_i,
    output logic [AGENTS_NUM-1:0][RESOURCES_NUM-1:0] grants_o
);

    logic [AGENTS_NUM-1:0][RESOURCES_NUM-1:0] agent_grants;    // One survivor per row.
    logic [RESOURCES_NUM-1:0][AGENTS_NUM-1:0] resource_reqs;
    logic [RESOURCES_NUM-1:0][AGENTS_NUM-1:0] resource_grants;

    // Each agent keeps one of its requests.
    for (genvar a = 0; a < AGENTS_NUM; a++)
    begin : g_agent_arb
        round_robin_arbiter #(
            .AGENTS_NUM (RESOURCES_NUM)
        ) u_agent_arb (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .requests_i (requests_i[a]),
            .grants_o   (agent_grants[a])
        );
    end

    // Each resource then picks one of the surviving agents.
    for (genvar r = 0; r < RESOURCES_NUM; r++)
    begin : g_resource_arb
        round_robin_arbiter #(
            .AGENTS_NUM (AGENTS_NUM)
        ) u_resource_arb (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .requests_i (resource_reqs[r]),
            .grants_o   (resource_grants[r])
        );
    end

    always_comb
    begin
        for (int a = 0; a < AGENTS_NUM; a++)
        begin
            for (int r = 0; r < RESOURCES_NUM; r++)
            begin
                resource_reqs[r][a] = agent_grants[a][r];    // Transpose.
                grants_o[a][r]      = resource_grants[r][a];
            end
        end
    end

endmodule

// File: round_robin_arbiter.sv
`timescale 1ns/1ps

module round_robin_arbiter #(
    parameter int AGENTS_NUM = 2
)(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [AGENTS_NUM-1:0] requests_i,
    output logic [AGENTS_NUM-1:0] grants_o
);

    localparam int PTR_SIZE = (AGENTS_NUM > 1) ? $clog2(AGENTS_NUM) : 1;

    logic [PTR_SIZE-1:0] pointer;      // Agent with the highest priority.
    logic [PTR_SIZE-1:0] grant_idx;
    logic                granted;

    // Search from the pointer upwards, wrapping around.
    always_comb
    begin
        int idx;
        grants_o  = '0;
        granted   = 1'b0;
        grant_idx = '0;
        for (int i = 0; i < AGENTS_NUM; i++)
        begin
            idx = (int'(pointer) + i) % AGENTS_NUM;
            if (!granted && requests_i[idx])
            begin
                granted       = 1'b1;
                grant_idx     = PTR_SIZE'(idx);
                grants_o[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pointer <= '0;
        else if (granted)
            pointer <= (grant_idx == PTR_SIZE'(AGENTS_NUM - 1)) ? '0 : grant_idx + 1'b1;
    end

endmodule

// File: flit_pkg.sv
package flit_pkg;

    import noc_params::*;

    localparam int PAYLOAD_SIZE = 32;
    localparam int DATA_SIZE    = PAYLOAD_SIZE - 2 * COORD_SIZE;

    typedef enum logic [1:0]
    {
        HEAD     = 2'b00,
        BODY     = 2'b01,
        TAIL     = 2'b10,
        HEADTAIL = 2'b11    // Single flit packet.
    } flit_type_e;

    // Route header carried in the payload of head flits.
    typedef struct packed
    {
        logic [COORD_SIZE-1:0] dest_x;
        logic [COORD_SIZE-1:0] dest_y;
        logic [DATA_SIZE-1:0]  data;
    } head_payload_t;

    // Head flits read the word as a header, body and tail flits as raw data.
    typedef union packed
    {
        head_payload_t           head;
        logic [PAYLOAD_SIZE-1:0] data;
    } payload_u;

    typedef struct packed
    {
        flit_type_e         flit_type;
        logic [VC_SIZE-1:0] vc_id;
        payload_u           payload;
    } flit_t;    // 35 bits with two VCs.

endpackage

// File: noc_params.sv
package noc_params;

    // Router geometry.
    localparam int PORT_NUM   = 5;
    localparam int VC_NUM     = 2;    // Default, the top level may override it.

    // Index widths.
    localparam int PORT_SIZE  = $clog2(PORT_NUM);
    localparam int VC_SIZE    = (VC_NUM > 1) ? $clog2(VC_NUM) : 1;

    // Mesh coordinates, enough for a 16 by 16 mesh.
    localparam int COORD_SIZE = 4;

    // Port numbering, shared by the input and output sides.
    typedef enum logic [PORT_SIZE-1:0]
    {
        LOCAL = 3'd0,
        NORTH = 3'd1,    // Towards larger y.
        SOUTH = 3'd2,
        EAST  = 3'd3,    // Towards larger x.
        WEST  = 3'd4
    } port_e;

endpackage
